// ==== fetch_unit.f ====
+incdir+logic
logic/isa_pkg.sv
logic/fetch_pkg.sv
logic/fetch_pc_gen.sv
logic/branch_target_buffer.sv
logic/imem_arbiter_bram.sv
logic/fetch_stage_bram.sv
logic/fetch_unit.sv
verif/tb_clock.sv
verif/fetch_unit_chk.sv
verif/fetch_unit_tb.sv

// ==== logic/branch_target_buffer.sv ====
`include "fetch_macros.svh"

module branch_target_buffer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  isa_pkg::addr_t         lookup_addr,
  output fetch_pkg::pred_t       pred,
  input  logic                   update,
  input  fetch_pkg::btb_update_t update_data
);

  // Index comes from word address bits, the rest of the address is the tag
  localparam int IW = $clog2(`FETCH_BTB_ENTRIES);
  localparam int TW = `FETCH_XLEN - IW - 2;

  logic [`FETCH_BTB_ENTRIES-1:0] valid_q;
  logic [TW-1:0]                 tag_q    [`FETCH_BTB_ENTRIES];
  isa_pkg::addr_t                target_q [`FETCH_BTB_ENTRIES];

  logic [IW-1:0] rd_idx;
  logic [TW-1:0] rd_tag;
  logic [IW-1:0] wr_idx;
  logic          hit;

  assign rd_idx = lookup_addr[IW+1:2];
  assign rd_tag = lookup_addr[`FETCH_XLEN-1:IW+2];
  assign wr_idx = update_data.pc[IW+1:2];

  // Full tag compare, so aliasing branches never steer fetch
  assign hit = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);

  // Every stored branch is treated as taken
  always_comb begin
    pred.hit    = hit;
    pred.taken  = hit;
    pred.target = target_q[rd_idx];
  end

  // Only the valid bits need clearing, a stale tag is harmless without them
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (update) begin
      valid_q[wr_idx] <= 1'b1;
    end
  end

  // Update lands at the edge, lookups see it from the next cycle on
  always_ff @(posedge clk) begin
    if (update) begin
      tag_q[wr_idx]    <= update_data.pc[`FETCH_XLEN-1:IW+2];
      target_q[wr_idx] <= update_data.target;
    end
  end

endmodule

// ==== logic/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// Width of a byte address on the fetch side
`define FETCH_XLEN 32

// Instruction RAM depth in 32-bit words
`define FETCH_IMEM_WORDS 256

// Number of direct-mapped branch target buffer entries, a power of two
`define FETCH_BTB_ENTRIES 16

`endif

// ==== logic/fetch_pc_gen.sv ====
module fetch_pc_gen (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              redirect,
  input  isa_pkg::addr_t    redirect_pc,
  input  fetch_pkg::pred_t  pred,
  input  logic              m_ready,
  input  logic              fetch_grant,
  output isa_pkg::addr_t    fetch_addr,
  output fetch_pkg::pred_t  pred_fetch,
  output logic              advance
);

  // Address of the most recent fetch that actually went to the RAM
  isa_pkg::addr_t pc;
  isa_pkg::addr_t pc_next;
  // Redirect that arrived while fetch was stalled and is still owed
  logic           pend;
  isa_pkg::addr_t pend_pc;
  // Low until the first fetch after reset, so address zero goes out first
  logic           primed;

  // Fetch only moves when the consumer accepts and the RAM port is ours
  assign advance = m_ready && fetch_grant;

  // Next address, redirect first, then a held redirect, then the prediction
  always_comb begin
    if (redirect) begin
      pc_next = redirect_pc;
    end else if (pend) begin
      pc_next = pend_pc;
    end else if (pred_fetch.hit && pred_fetch.taken) begin
      pc_next = pred_fetch.target;
    end else if (primed) begin
      pc_next = pc + isa_pkg::INSTR_BYTES;
    end else begin
      pc_next = pc;
    end
  end

  // Early fetch: the RAM sees the next address in the same cycle
  assign fetch_addr = pc_next;

  // Prediction is captured with its address so it lines up with the RAM data
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc         <= '0;
      pred_fetch <= '0;
      primed     <= 1'b0;
      pend       <= 1'b0;
    end else if (advance) begin
      pc         <= pc_next;
      pred_fetch <= pred;
      primed     <= 1'b1;
      pend       <= 1'b0;
    end else if (redirect) begin
      pend <= 1'b1;
    end
  end

  // Target of a stalled redirect, only meaningful while pend is set
  always_ff @(posedge clk) begin
    if (redirect) begin
      pend_pc <= redirect_pc;
    end
  end

endmodule

// ==== logic/fetch_pkg.sv ====
`include "fetch_macros.svh"

// Bundles that travel between the blocks of the fetch front end
package fetch_pkg;

  // Word index width of the instruction RAM
  localparam int IMEM_AW = $clog2(`FETCH_IMEM_WORDS);

  // Branch target buffer answer for one fetch address
  typedef struct packed {
    logic           hit;
    logic           taken;
    isa_pkg::addr_t target;
  } pred_t;

  // One fetched slot handed to the consumer
  typedef struct packed {
    logic            valid;
    isa_pkg::addr_t  pc;
    isa_pkg::addr_t  pc_plus4;
    isa_pkg::instr_t instr;
    pred_t           pred;
  } fetch_bundle_t;

  // Write of one branch into the buffer, keyed by the branch PC
  typedef struct packed {
    isa_pkg::addr_t pc;
    isa_pkg::addr_t target;
  } btb_update_t;

  // Program loader write into the instruction RAM, addressed in words
  typedef struct packed {
    logic [IMEM_AW-1:0] addr;
    isa_pkg::instr_t    data;
  } imem_load_t;

endpackage

// ==== logic/fetch_stage_bram.sv ====
module fetch_stage_bram (
  input  logic                     clk,
  input  logic                     rst_n,
  input  isa_pkg::addr_t           fetch_addr,
  input  logic                     m_ready,
  input  logic                     if_id_flush,
  input  fetch_pkg::pred_t         pred_if,
  output logic                     imem_ren,
  output isa_pkg::addr_t           imem_raddr,
  input  isa_pkg::instr_t          imem_rdata,
  output fetch_pkg::fetch_bundle_t bundle
);

  // Address whose word is sitting in the RAM output register
  isa_pkg::addr_t   addr_q;
  // Slot in the RAM output is a real fetch and not a reset or stale leftover
  logic             started;

  // Output slot registers
  logic             valid_q;
  isa_pkg::addr_t   pc_q;
  isa_pkg::addr_t   pc_plus4_q;
  isa_pkg::instr_t  instr_q;
  fetch_pkg::pred_t pred_q;

  // The RAM is addressed with the next PC, one cycle ahead of the slot
  assign imem_raddr = fetch_addr;

  // Read enable follows reset so the RAM is already running when it ends
  assign imem_ren = !rst_n || m_ready;

  // Track the address beside the RAM read so they stay paired under stalls
  always_ff @(posedge clk) begin
    if (m_ready) begin
      addr_q <= fetch_addr;
    end
  end

  // First advancing cycle after reset only fills the RAM output
  // A flush while stalled leaves a wrong-path word there, so it is dropped
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      started <= 1'b0;
    end else if (m_ready) begin
      started <= 1'b1;
    end else if (if_id_flush) begin
      started <= 1'b0;
    end
  end

  // PC, PC plus 4 and prediction keep moving through a flush
  // Only the instruction and its valid bit are killed
  always_ff @(posedge clk) begin
    if (m_ready) begin
      pc_q       <= addr_q;
      pc_plus4_q <= addr_q + isa_pkg::INSTR_BYTES;
      pred_q     <= pred_if;
    end
  end

  // Instruction register, NOP on reset and on flush
  always_ff @(posedge clk) begin
    if (!rst_n || if_id_flush) begin
      instr_q <= isa_pkg::I_NOP;
    end else if (m_ready) begin
      instr_q <= imem_rdata;
    end
  end

  // Slot validity, it lags the started flag by one advancing cycle
  always_ff @(posedge clk) begin
    if (!rst_n || if_id_flush) begin
      valid_q <= 1'b0;
    end else if (m_ready) begin
      valid_q <= started;
    end
  end

  always_comb begin
    bundle.valid    = valid_q;
    bundle.pc       = pc_q;
    bundle.pc_plus4 = pc_plus4_q;
    bundle.instr    = instr_q;
    bundle.pred     = pred_q;
  end

endmodule

// ==== logic/fetch_unit.sv ====
module fetch_unit (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     redirect,
  input  isa_pkg::addr_t           redirect_pc,
  input  logic                     btb_update,
  input  fetch_pkg::btb_update_t   btb_update_data,
  input  logic                     load,
  input  fetch_pkg::imem_load_t    load_data,
  input  logic                     m_ready,
  output fetch_pkg::fetch_bundle_t bundle
);

  isa_pkg::addr_t   fetch_addr;
  fetch_pkg::pred_t pred;
  fetch_pkg::pred_t pred_fetch;
  logic             advance;
  logic             fetch_grant;
  logic             imem_ren;
  isa_pkg::addr_t   imem_raddr;
  isa_pkg::instr_t  imem_rdata;

  // Next address selection and the stall decision
  fetch_pc_gen u_pc_gen (
    .clk         (clk),
    .rst_n       (rst_n),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .pred        (pred),
    .m_ready     (m_ready),
    .fetch_grant (fetch_grant),
    .fetch_addr  (fetch_addr),
    .pred_fetch  (pred_fetch),
    .advance     (advance)
  );

  // Looks up the address that is being fetched right now
  branch_target_buffer u_btb (
    .clk         (clk),
    .rst_n       (rst_n),
    .lookup_addr (fetch_addr),
    .pred        (pred),
    .update      (btb_update),
    .update_data (btb_update_data)
  );

  // Loader and fetch share the one RAM port
  imem_arbiter_bram u_imem (
    .clk         (clk),
    .rst_n       (rst_n),
    .ren         (imem_ren),
    .raddr       (imem_raddr),
    .rdata       (imem_rdata),
    .load        (load),
    .load_data   (load_data),
    .fetch_grant (fetch_grant)
  );

  // Stage sees advance as its ready and a redirect as its flush
  fetch_stage_bram u_stage (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_addr  (fetch_addr),
    .m_ready     (advance),
    .if_id_flush (redirect),
    .pred_if     (pred_fetch),
    .imem_ren    (imem_ren),
    .imem_raddr  (imem_raddr),
    .imem_rdata  (imem_rdata),
    .bundle      (bundle)
  );

endmodule

// ==== logic/imem_arbiter_bram.sv ====
`include "fetch_macros.svh"

module imem_arbiter_bram (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  ren,
  input  isa_pkg::addr_t        raddr,
  output isa_pkg::instr_t       rdata,
  input  logic                  load,
  input  fetch_pkg::imem_load_t load_data,
  output logic                  fetch_grant
);

  localparam int AW = fetch_pkg::IMEM_AW;

  isa_pkg::instr_t mem [`FETCH_IMEM_WORDS];

  logic [AW-1:0] ridx;
  logic          rd_fire;

  // Byte address to word index, low two bits are always zero for RV32
  assign ridx = raddr[AW+1:2];

  // The loader owns the single port in any cycle it strobes
  assign fetch_grant = !load;

  // A read happens only when fetch holds the port and asks for it
  assign rd_fire = ren && fetch_grant;

  // Write side of the port, used by the program loader only
  always_ff @(posedge clk) begin
    if (load) begin
      mem[load_data.addr] <= load_data.data;
    end
  end

  // Registered read, output holds on load cycles and when no read is asked
  // Reset puts a NOP here so nothing random leaks out before the first read
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rdata <= isa_pkg::I_NOP;
    end else if (rd_fire) begin
      rdata <= mem[ridx];
    end
  end

endmodule

// ==== logic/isa_pkg.sv ====
`include "fetch_macros.svh"

// RV32 view of the instruction stream as seen by the fetch front end
package isa_pkg;

  // Instructions are always 32 bits wide in RV32 without the C extension
  localparam int ILEN = 32;

  // One raw instruction word as it comes out of the instruction RAM
  typedef logic [ILEN-1:0] instr_t;

  // Byte address used for the PC and for every fetch target
  typedef logic [`FETCH_XLEN-1:0] addr_t;

  // Canonical NOP is addi x0, x0, 0
  // Opcode OP-IMM is 7'b0010011 and every other field is zero
  localparam instr_t I_NOP = 32'h0000_0013;

  // Sequential step between two instructions in bytes
  localparam addr_t INSTR_BYTES = addr_t'(ILEN / 8);

endpackage

// ==== run_sim.sh ====
#!/bin/sh
set -e

verilator --binary --timing --assert -Ilogic --top-module fetch_unit_tb \
  -f fetch_unit.f -o fetch_sim

# The simulation status is not trusted, the log decides
./obj_dir/fetch_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "All checks passed" sim.log; then
  exit 0
fi
exit 1

// ==== verif/fetch_unit_chk.sv ====
module fetch_unit_chk (
  input logic                     clk,
  input logic                     rst_n,
  input logic                     m_ready,
  input logic                     if_id_flush,
  input fetch_pkg::fetch_bundle_t bundle
);

  timeunit 1ns;
  timeprecision 100ps;

  // The first cycle out of reset only primes the RAM, so no slot is offered yet
  valid_after_reset: assert property (@(posedge clk) $rose(rst_n) |=> !bundle.valid)
    else $error("bundle valid in the cycle after reset");

  // A stalled slot must not move unless a flush kills it
  hold_on_stall: assert property (@(posedge clk)
    (rst_n && !m_ready && !if_id_flush) |=> $stable(bundle))
    else $error("bundle changed while ready was low");

  // Flushed slot carries a NOP and is never offered
  flush_to_nop: assert property (@(posedge clk)
    (rst_n && if_id_flush) |=> (!bundle.valid && bundle.instr == isa_pkg::I_NOP))
    else $error("flushed slot is not an invalid NOP");

endmodule

bind fetch_stage_bram fetch_unit_chk chk0 (
  .clk         (clk),
  .rst_n       (rst_n),
  .m_ready     (m_ready),
  .if_id_flush (if_id_flush),
  .bundle      (bundle)
);

// ==== verif/fetch_unit_tb.sv ====
module fetch_unit_tb;

  timeunit 1ns;
  timeprecision 100ps;

  logic                     clk;
  logic                     rst_n;
  logic                     redirect;
  isa_pkg::addr_t           redirect_pc;
  logic                     btb_update;
  fetch_pkg::btb_update_t   btb_update_data;
  logic                     load;
  fetch_pkg::imem_load_t    load_data;
  logic                     m_ready;
  fetch_pkg::fetch_bundle_t bundle;

  logic [31:0]     vec [0:127];
  // Reference copies of the program and of the taken branches
  isa_pkg::instr_t model_mem [256];
  isa_pkg::addr_t  model_btb [isa_pkg::addr_t];
  isa_pkg::addr_t  exp_pc;
  int errors, checks, test_errs, accepted, tests, cycles, limit, seed_val;

  tb_clock clk0 (.clk(clk), .rst_n(rst_n));

  fetch_unit dut0 (
    .clk(clk), .rst_n(rst_n), .redirect(redirect), .redirect_pc(redirect_pc),
    .btb_update(btb_update), .btb_update_data(btb_update_data), .load(load),
    .load_data(load_data), .m_ready(m_ready), .bundle(bundle)
  );

  function automatic string test_name(input logic [31:0] id);
    case (id)
      1: return "sequential";
      2: return "redirect";
      3: return "prediction";
      4: return "back_pressure";
      default: return "load_during_fetch";
    endcase
  endfunction

  task automatic fail_plain(input string what);
    errors++;
    test_errs++;
    $display("%s", what);
  endtask

  task automatic check_bundle(input string name, input fetch_pkg::fetch_bundle_t exp,
                              input fetch_pkg::fetch_bundle_t act);
    checks++;
    if (exp.valid !== act.valid || exp.pc !== act.pc || exp.pc_plus4 !== act.pc_plus4 ||
        exp.instr !== act.instr) begin
      errors++;
      test_errs++;
      $display("error %s: expected pc %h pc_plus4 %h instr %h, actual pc %h pc_plus4 %h instr %h",
               name, exp.pc, exp.pc_plus4, exp.instr, act.pc, act.pc_plus4, act.instr);
    end
  endtask

  // Target only matters on a hit
  task automatic check_pred(input string name, input fetch_pkg::pred_t exp,
                            input fetch_pkg::pred_t act);
    checks++;
    if (exp.hit !== act.hit || exp.taken !== act.taken ||
        (exp.hit && exp.target !== act.target)) begin
      errors++;
      test_errs++;
      $display("error %s: expected pred %h, actual pred %h", name, exp, act);
    end
  endtask

  // Runs at the falling edge, when inputs and the bundle are both settled
  task automatic observe(input string name);
    fetch_pkg::fetch_bundle_t exp;
    fetch_pkg::pred_t         ep;
    // A load owns the RAM port, so the consumer sees no transfer that cycle
    if (bundle.valid && m_ready && !load) begin
      accepted++;
      ep.hit       = model_btb.exists(exp_pc);
      ep.taken     = ep.hit;
      ep.target    = ep.hit ? model_btb[exp_pc] : '0;
      exp.valid    = 1'b1;
      exp.pc       = exp_pc;
      exp.pc_plus4 = exp_pc + 32'd4;
      exp.instr    = model_mem[exp_pc[9:2]];
      exp.pred     = ep;
      check_bundle(name, exp, bundle);
      check_pred(name, ep, bundle.pred);
      exp_pc = ep.hit ? ep.target : exp_pc + 32'd4;
    end
    // Redirect wins over whatever the sequence would have been
    if (redirect) begin
      exp_pc = redirect_pc;
    end
  endtask

  task automatic tick(input string name, input logic red, input isa_pkg::addr_t rpc,
                      input logic upd, input fetch_pkg::btb_update_t ud, input logic ld,
                      input fetch_pkg::imem_load_t ldd, input logic rdy);
    @(posedge clk);
    #1;
    redirect        = red;
    redirect_pc     = rpc;
    btb_update      = upd;
    btb_update_data = ud;
    load            = ld;
    load_data       = ldd;
    m_ready         = rdy;
    @(negedge clk);
    observe(name);
  endtask

  task automatic finish_test(input string name);
    if (accepted == 0) begin
      fail_plain($sformatf("%s: no bundle was accepted", name));
    end
    tests++;
    $display("%s: %0d bundles accepted, %0d errors", name, accepted, test_errs);
    accepted  = 0;
    test_errs = 0;
  endtask

  // Hard stop so a stuck handshake cannot hang the run
  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles > limit) begin
      $display("timeout after %0d cycles, the run did not finish", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  initial begin
    fetch_pkg::btb_update_t ud;
    fetch_pkg::imem_load_t  ldd;
    logic [31:0] op, a, b, n;
    string name;
    redirect        = 1'b0;
    redirect_pc     = '0;
    btb_update      = 1'b0;
    btb_update_data = '0;
    load            = 1'b0;
    load_data       = '0;
    m_ready         = 1'b0;
    seed_val        = $urandom(71634);
    $readmemh("verif/fetch_vectors.txt", vec);
    // Budget is four times the summed record lengths plus the reset window
    for (int r = 0; r < 32 && vec[r*4] inside {[1:6]}; r++) begin
      limit += vec[r*4+3] + 1;
    end
    limit = 4 * (limit + 10);

    // Valid must stay low through reset and the first cycle after it
    // Ready is high through reset so the first free cycle really advances
    name = "reset";
    while (!rst_n) begin
      tick(name, 0, '0, 0, '0, 0, '0, 1);
      if (bundle.valid) fail_plain("reset: bundle valid while reset is asserted");
    end
    // The word read in that first cycle predates the program, a stalled redirect drops it
    tick(name, 1, '0, 0, '0, 0, '0, 0);
    if (bundle.valid) fail_plain("reset: bundle valid in the first cycle after reset");
    accepted = 1;
    finish_test(name);

    exp_pc = '0;
    name   = test_name(1);
    for (int r = 0; r < 32 && vec[r*4] inside {[1:6]}; r++) begin
      op = vec[r*4];
      a  = vec[r*4+1];
      b  = vec[r*4+2];
      n  = vec[r*4+3];
      case (op)
        1: begin
          for (int k = 0; k < int'(n); k++) begin
            ldd.addr = 8'(a + k);
            ldd.data = b + k;
            model_mem[ldd.addr] = ldd.data;
            tick(name, 0, '0, 0, '0, 1, ldd, 0);
          end
        end
        2: begin
          ud.pc     = a;
          ud.target = b;
          model_btb[a] = b;
          tick(name, 0, '0, 1, ud, 0, '0, 0);
        end
        3: tick(name, 1, a, 0, '0, 0, '0, 1);
        4: begin
          for (int k = 0; k < int'(n); k++) begin
            tick(name, 0, '0, 0, '0, 0, '0, b[0] ? (($urandom % 4) != 0) : 1'b1);
          end
        end
        5: begin
          ldd.addr = a[7:0];
          ldd.data = b;
          model_mem[ldd.addr] = b;
          tick(name, 0, '0, 0, '0, 1, ldd, 1);
        end
        default: begin
          finish_test(name);
          name = test_name(a + 1);
        end
      endcase
    end

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== verif/fetch_vectors.txt ====
// Columns: op addr data count, one record per line, all hex
// Op 1 program load of count words from word addr with data+index
// Op 2 buffer update branch pc addr to target data
// Op 3 redirect to addr
// Op 4 run count cycles, data 1 gives random ready gaps
// Op 5 load during fetch of word addr with data
// Op 6 end of test number addr, op 0 ends the file
1 00000000 10000000 00000100
4 00000000 00000000 00000014
6 00000001 00000000 00000000
3 00000080 00000000 00000000
4 00000000 00000000 0000000c
6 00000002 00000000 00000000
2 00000090 00000040 00000000
3 00000088 00000000 00000000
4 00000000 00000000 00000010
6 00000003 00000000 00000000
4 00000000 00000001 00000028
6 00000004 00000000 00000000
3 00000000 00000000 00000000
5 00000010 deadbeef 00000000
4 00000000 00000000 0000001e
6 00000005 00000000 00000000
0 00000000 00000000 00000000

// ==== verif/tb_clock.sv ====
module tb_clock (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  // 20 ns period
  initial clk = 1'b0;
  always #10 clk = ~clk;

  // Reset held for 8 rising edges, released just after the last one
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge clk);
    #1 rst_n = 1'b1;
  end

endmodule
